/* all.f */
hw/issue_pkg.sv
hw/pair_hazard.sv
hw/int_regfile.sv
hw/csr_file.sv
hw/issue_stage.sv
hw/issue_top.sv
sim/issue_tb.sv

/* hw/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
  input  logic clock,
  input  logic reset,
  input  issue_pkg::csr_addr_t caddr,
  output logic [issue_pkg::xlen-1:0] cdata,
  input  logic wren,
  input  logic [issue_pkg::csr_addr_w-1:0] waddr,
  input  logic [issue_pkg::xlen-1:0] wdata
);

  logic [issue_pkg::xlen-1:0] mstatus;
  logic [issue_pkg::xlen-1:0] mscratch;
  logic [issue_pkg::xlen-1:0] mepc;
  logic [issue_pkg::xlen-1:0] mcause;

  always_ff @(posedge clock) begin
    if (!reset) begin
      mstatus <= '0;
      mscratch <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (wren) begin
      // writes to unknown addresses are dropped.
      case (waddr)
        issue_pkg::csr_mstatus: begin
          mstatus <= wdata;
        end
        issue_pkg::csr_mscratch: begin
          mscratch <= wdata;
        end
        issue_pkg::csr_mepc: begin
          mepc <= wdata;
        end
        issue_pkg::csr_mcause: begin
          mcause <= wdata;
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    case (caddr)
      issue_pkg::csr_mstatus:  cdata = mstatus;
      issue_pkg::csr_mscratch: cdata = mscratch;
      issue_pkg::csr_mepc:     cdata = mepc;
      issue_pkg::csr_mcause:   cdata = mcause;
      default:                 cdata = '0;
    endcase
  end

endmodule

/* hw/int_regfile.sv */
`timescale 1ns/1ps

module int_regfile (
  input  logic clock,
  input  logic reset,
  input  issue_pkg::rd_req_t raddr,
  output issue_pkg::rd_data_t rdata,
  input  issue_pkg::wb_t wb0,
  input  issue_pkg::wb_t wb1
);

  // x0 has no storage.
  logic [issue_pkg::xlen-1:0] regs [1:issue_pkg::reg_count-1];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 1; i < issue_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb0.wren && wb0.waddr != '0) begin
        regs[wb0.waddr] <= wb0.wdata;
      end
      // younger lane written last so it wins on a collision.
      if (wb1.wren && wb1.waddr != '0) begin
        regs[wb1.waddr] <= wb1.wdata;
      end
    end
  end

  // asynchronous read, no bypass from the write ports.
  always_comb begin
    for (int p = 0; p < issue_pkg::rd_ports; p++) begin
      if (raddr.port[p].en && raddr.port[p].addr != '0) begin
        rdata.data[p] = regs[raddr.port[p].addr];
      end else begin
        rdata.data[p] = '0;
      end
    end
  end

endmodule

/* hw/issue_pkg.sv */
package issue_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;
  localparam int reg_count = 32;
  localparam int rd_ports = 4;

  typedef enum logic [2:0] {
    op_nop,
    op_alu,
    op_load,
    op_store,
    op_csrr,
    op_csrw
  } opcode_t;

  // machine csr addresses from the privileged spec.
  typedef enum logic [csr_addr_w-1:0] {
    csr_mstatus  = 12'h300,
    csr_mscratch = 12'h340,
    csr_mepc     = 12'h341,
    csr_mcause   = 12'h342
  } csr_addr_t;

  typedef struct packed {
    opcode_t opcode;
    logic rden1;
    logic rden2;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic wren;
    logic [reg_addr_w-1:0] waddr;
    csr_addr_t caddr;
  } instr_t;

  typedef struct packed {
    instr_t instr0;
    instr_t instr1;
  } pair_t;

  typedef struct packed {
    logic load0;
    logic load1;
    logic [reg_addr_w-1:0] waddr0;
    logic [reg_addr_w-1:0] waddr1;
    logic cwren;
    logic stall;
  } ex_status_t;

  typedef struct packed {
    logic cwren;
    logic stall;
  } mem_status_t;

  typedef struct packed {
    logic trap;
    logic mret;
    logic mispredict;
  } redirect_t;

  typedef struct packed {
    logic wren;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0] wdata;
  } wb_t;

  typedef struct packed {
    instr_t instr;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] cdata;
  } issued_t;

  typedef struct packed {
    logic en;
    logic [reg_addr_w-1:0] addr;
  } rd_port_t;

  // ports 0 and 1 serve lane 0, ports 2 and 3 serve lane 1.
  typedef struct packed {
    rd_port_t [rd_ports-1:0] port;
  } rd_req_t;

  typedef struct packed {
    logic [rd_ports-1:0][xlen-1:0] data;
  } rd_data_t;

  localparam instr_t nop_instr = '{
    opcode: op_nop,
    rden1: 1'b0,
    rden2: 1'b0,
    raddr1: '0,
    raddr2: '0,
    wren: 1'b0,
    waddr: '0,
    caddr: csr_mstatus
  };

  localparam issued_t nop_lane = '{instr: nop_instr, op1: '0, op2: '0, cdata: '0};

  // true when either enabled source of instr is addr.
  function automatic logic reads_reg(input instr_t instr, input logic [reg_addr_w-1:0] addr);
    return (instr.rden1 && instr.raddr1 == addr) || (instr.rden2 && instr.raddr2 == addr);
  endfunction

endpackage

/* hw/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
  input  logic clock,
  input  logic reset,
  input  issue_pkg::pair_t ordered,
  input  logic swap_in,
  input  logic split,
  input  logic dec_valid,
  input  issue_pkg::ex_status_t ex,
  input  issue_pkg::mem_status_t mem,
  input  issue_pkg::redirect_t redirect,
  output issue_pkg::rd_req_t raddr,
  input  issue_pkg::rd_data_t rdata,
  output issue_pkg::csr_addr_t caddr,
  input  logic [issue_pkg::xlen-1:0] cdata,
  output issue_pkg::issued_t lane0,
  output issue_pkg::issued_t lane1,
  output logic swap,
  output logic hold,
  output logic issue_stall
);

  logic clear;
  logic down_stall;
  logic cur_swap;
  logic cur_split;
  logic load_hz0;
  logic load_hz1;
  logic stall_hz;
  logic csr_rd;
  issue_pkg::pair_t cur;
  issue_pkg::issued_t lane0_d;
  issue_pkg::issued_t lane1_d;
  logic swap_d;

  // read requests come only from the decoded pair.
  always_comb begin
    // invalid decode slot behaves as a nop pair.
    if (dec_valid) begin
      cur = ordered;
    end else begin
      cur.instr0 = issue_pkg::nop_instr;
      cur.instr1 = issue_pkg::nop_instr;
    end
    cur_swap = dec_valid & swap_in;
    cur_split = dec_valid & split;

    raddr.port[0].en = cur.instr0.rden1;
    raddr.port[0].addr = cur.instr0.raddr1;
    raddr.port[1].en = cur.instr0.rden2;
    raddr.port[1].addr = cur.instr0.raddr2;
    raddr.port[2].en = cur.instr1.rden1;
    raddr.port[2].addr = cur.instr1.raddr1;
    raddr.port[3].en = cur.instr1.rden2;
    raddr.port[3].addr = cur.instr1.raddr2;
    caddr = cur.instr0.caddr;
  end

  always_comb begin
    clear = redirect.trap | redirect.mret | redirect.mispredict;
    down_stall = ex.stall | mem.stall;

    // load results are not ready until after memory.
    load_hz0 = ex.load0 && (ex.waddr0 != '0) &&
               (issue_pkg::reads_reg(cur.instr0, ex.waddr0) ||
                issue_pkg::reads_reg(cur.instr1, ex.waddr0));
    load_hz1 = ex.load1 && (ex.waddr1 != '0) &&
               (issue_pkg::reads_reg(cur.instr0, ex.waddr1) ||
                issue_pkg::reads_reg(cur.instr1, ex.waddr1));
    stall_hz = ex.cwren | mem.cwren | load_hz0 | load_hz1;

    csr_rd = (cur.instr0.opcode == issue_pkg::op_csrr) ||
             (cur.instr0.opcode == issue_pkg::op_csrw);

    lane0_d.instr = cur.instr0;
    lane0_d.op1 = rdata.data[0];
    lane0_d.op2 = rdata.data[1];
    lane0_d.cdata = csr_rd ? cdata : '0;
    lane1_d.instr = cur.instr1;
    lane1_d.op1 = rdata.data[2];
    lane1_d.op2 = rdata.data[3];
    lane1_d.cdata = '0;
    swap_d = cur_swap;

    if (clear) begin
      lane0_d = issue_pkg::nop_lane;
      lane1_d = issue_pkg::nop_lane;
      swap_d = 1'b0;
    end else if (down_stall) begin
      lane0_d = lane0;
      lane1_d = lane1;
      swap_d = swap;
    end else if (stall_hz) begin
      lane0_d = issue_pkg::nop_lane;
      lane1_d = issue_pkg::nop_lane;
      swap_d = 1'b0;
    end

    // decode repeats the pair whenever it was not fully taken.
    hold = !clear && (cur_split || down_stall || stall_hz);
    issue_stall = !clear && stall_hz;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      lane0 <= issue_pkg::nop_lane;
      lane1 <= issue_pkg::nop_lane;
      swap <= 1'b0;
    end else begin
      lane0 <= lane0_d;
      lane1 <= lane1_d;
      swap <= swap_d;
    end
  end

endmodule

/* hw/issue_top.sv */
`timescale 1ns/1ps

module issue_top (
  input  logic clock,
  input  logic reset,
  input  issue_pkg::pair_t dec,
  input  logic dec_valid,
  input  issue_pkg::ex_status_t ex,
  input  issue_pkg::mem_status_t mem,
  input  issue_pkg::redirect_t redirect,
  input  issue_pkg::wb_t wb0,
  input  issue_pkg::wb_t wb1,
  input  logic csr_wren,
  input  logic [issue_pkg::csr_addr_w-1:0] csr_waddr,
  input  logic [issue_pkg::xlen-1:0] csr_wdata,
  output issue_pkg::issued_t lane0,
  output issue_pkg::issued_t lane1,
  output logic swap,
  output logic hold,
  output logic issue_stall
);

  issue_pkg::pair_t ordered;
  logic pair_swap;
  logic pair_split;
  issue_pkg::rd_req_t rd_req;
  issue_pkg::rd_data_t rd_data;
  issue_pkg::csr_addr_t csr_raddr;
  logic [issue_pkg::xlen-1:0] csr_rdata;

  pair_hazard pair_hazard_i (
    .dec     (dec),
    .ordered (ordered),
    .swap    (pair_swap),
    .split   (pair_split)
  );

  issue_stage issue_stage_i (
    .clock       (clock),
    .reset       (reset),
    .ordered     (ordered),
    .swap_in     (pair_swap),
    .split       (pair_split),
    .dec_valid   (dec_valid),
    .ex          (ex),
    .mem         (mem),
    .redirect    (redirect),
    .raddr       (rd_req),
    .rdata       (rd_data),
    .caddr       (csr_raddr),
    .cdata       (csr_rdata),
    .lane0       (lane0),
    .lane1       (lane1),
    .swap        (swap),
    .hold        (hold),
    .issue_stall (issue_stall)
  );

  int_regfile int_regfile_i (
    .clock (clock),
    .reset (reset),
    .raddr (rd_req),
    .rdata (rd_data),
    .wb0   (wb0),
    .wb1   (wb1)
  );

  csr_file csr_file_i (
    .clock (clock),
    .reset (reset),
    .caddr (csr_raddr),
    .cdata (csr_rdata),
    .wren  (csr_wren),
    .waddr (csr_waddr),
    .wdata (csr_wdata)
  );

endmodule

/* hw/pair_hazard.sv */
`timescale 1ns/1ps

module pair_hazard (
  input  issue_pkg::pair_t dec,
  output issue_pkg::pair_t ordered,
  output logic swap,
  output logic split
);

  logic need0_first;
  logic need0_second;
  logic raw;

  // loads, stores and csr accesses are lane 0 only.
  function automatic logic needs_lane0(input issue_pkg::instr_t instr);
    logic hit;
    hit = 1'b0;
    case (instr.opcode)
      issue_pkg::op_load,
      issue_pkg::op_store,
      issue_pkg::op_csrr,
      issue_pkg::op_csrw: begin
        hit = 1'b1;
      end
      default: begin
        hit = 1'b0;
      end
    endcase
    return hit;
  endfunction

  always_comb begin
    need0_first = needs_lane0(dec.instr0);
    need0_second = needs_lane0(dec.instr1);

    // second instruction consumes a result of the first.
    raw = dec.instr0.wren && (dec.instr0.waddr != '0) &&
          issue_pkg::reads_reg(dec.instr1, dec.instr0.waddr);

    split = raw || (need0_first && need0_second);
    swap = !split && need0_second && !need0_first;

    if (split) begin
      ordered.instr0 = dec.instr0;
      ordered.instr1 = issue_pkg::nop_instr;
    end else if (swap) begin
      ordered.instr0 = dec.instr1;
      ordered.instr1 = dec.instr0;
    end else begin
      ordered = dec;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module issue_tb -o issue_sim

./obj_dir/issue_sim > sim.log
cat sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sim/issue_tb.sv */
`timescale 1ns/1ps

module issue_tb;

  localparam int reset_cycles = 8;
  localparam int reg_writes = 12;
  localparam int alu_pairs = 16;
  localparam int directed_cycles = 32;
  localparam int max_cycles = reset_cycles + reg_writes + alu_pairs + directed_cycles + 100;

  logic clock;
  logic reset;
  issue_pkg::pair_t dec;
  logic dec_valid;
  issue_pkg::ex_status_t ex;
  issue_pkg::mem_status_t mem;
  issue_pkg::redirect_t redirect;
  issue_pkg::wb_t wb0;
  issue_pkg::wb_t wb1;
  logic csr_wren;
  logic [issue_pkg::csr_addr_w-1:0] csr_waddr;
  logic [issue_pkg::xlen-1:0] csr_wdata;
  issue_pkg::issued_t lane0;
  issue_pkg::issued_t lane1;
  logic swap;
  logic hold;
  logic issue_stall;

  issue_pkg::issued_t exp_lane0;
  issue_pkg::issued_t exp_lane1;
  issue_pkg::issued_t pend_lane0;
  issue_pkg::issued_t pend_lane1;
  logic exp_swap;
  logic pend_swap;
  logic exp_hold;
  logic exp_stall;
  logic checking;
  int errors = 0;
  int cycles = 0;
  integer seed;
  logic [issue_pkg::xlen-1:0] ref_regs [0:issue_pkg::reg_count-1];
  logic [issue_pkg::xlen-1:0] ref_csr [0:3];

  issue_top dut_i (
    .clock       (clock),
    .reset       (reset),
    .dec         (dec),
    .dec_valid   (dec_valid),
    .ex          (ex),
    .mem         (mem),
    .redirect    (redirect),
    .wb0         (wb0),
    .wb1         (wb1),
    .csr_wren    (csr_wren),
    .csr_waddr   (csr_waddr),
    .csr_wdata   (csr_wdata),
    .lane0       (lane0),
    .lane1       (lane1),
    .swap        (swap),
    .hold        (hold),
    .issue_stall (issue_stall)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic issue_pkg::instr_t make_instr(
    input issue_pkg::opcode_t opcode,
    input logic rden1,
    input logic [issue_pkg::reg_addr_w-1:0] raddr1,
    input logic rden2,
    input logic [issue_pkg::reg_addr_w-1:0] raddr2,
    input logic [issue_pkg::reg_addr_w-1:0] waddr
  );
    issue_pkg::instr_t i;
    i = issue_pkg::nop_instr;
    i.opcode = opcode;
    i.rden1 = rden1;
    i.raddr1 = raddr1;
    i.rden2 = rden2;
    i.raddr2 = raddr2;
    i.wren = (waddr != '0);
    i.waddr = waddr;
    return i;
  endfunction

  function automatic logic [1:0] csr_slot(input issue_pkg::csr_addr_t a);
    case (a)
      issue_pkg::csr_mscratch: return 2'd1;
      issue_pkg::csr_mepc:     return 2'd2;
      issue_pkg::csr_mcause:   return 2'd3;
      default:                 return 2'd0;
    endcase
  endfunction

  function automatic issue_pkg::issued_t bubble();
    issue_pkg::issued_t l;
    l.instr = issue_pkg::nop_instr;
    l.op1 = '0;
    l.op2 = '0;
    l.cdata = '0;
    return l;
  endfunction

  // operands from the model, csr value only in lane 0.
  function automatic issue_pkg::issued_t expect_lane(input issue_pkg::instr_t i,
                                                      input logic first);
    issue_pkg::issued_t l;
    l.instr = i;
    l.op1 = i.rden1 ? ref_regs[i.raddr1] : '0;
    l.op2 = i.rden2 ? ref_regs[i.raddr2] : '0;
    l.cdata = '0;
    if (first && (i.opcode == issue_pkg::op_csrr || i.opcode == issue_pkg::op_csrw)) begin
      l.cdata = ref_csr[csr_slot(i.caddr)];
    end
    return l;
  endfunction

  function automatic logic [issue_pkg::xlen-1:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [issue_pkg::reg_addr_w-1:0] rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[4:0];
  endfunction

  task automatic lane_mismatch(input string name, input issue_pkg::issued_t e,
                               input issue_pkg::issued_t a);
    errors++;
    $display("[FAIL] %0t %s expected %h actual %h", $time, name, e, a);
  endtask

  task automatic flag_mismatch(input string name, input logic e, input logic a);
    errors++;
    $display("[FAIL] %0t %s expected %b actual %b", $time, name, e, a);
  endtask

  assert property (@(negedge clock) disable iff (!checking) lane0 === exp_lane0)
    else lane_mismatch("lane0", exp_lane0, lane0);
  assert property (@(negedge clock) disable iff (!checking) lane1 === exp_lane1)
    else lane_mismatch("lane1", exp_lane1, lane1);
  assert property (@(negedge clock) disable iff (!checking) swap === exp_swap)
    else flag_mismatch("swap", exp_swap, swap);
  assert property (@(negedge clock) disable iff (!checking) hold === exp_hold)
    else flag_mismatch("hold", exp_hold, hold);
  assert property (@(negedge clock) disable iff (!checking) issue_stall === exp_stall)
    else flag_mismatch("issue_stall", exp_stall, issue_stall);

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic idle_inputs();
    dec.instr0 = issue_pkg::nop_instr;
    dec.instr1 = issue_pkg::nop_instr;
    dec_valid = 1'b0;
    ex = '0;
    mem = '0;
    redirect = '0;
    wb0 = '0;
    wb1 = '0;
    csr_wren = 1'b0;
    pend_lane0 = bubble();
    pend_lane1 = bubble();
    pend_swap = 1'b0;
    exp_hold = 1'b0;
    exp_stall = 1'b0;
  endtask

  // lanes expected now are the ones predicted a cycle ago.
  task automatic tick();
    @(posedge clock);
    #1;
    exp_lane0 = pend_lane0;
    exp_lane1 = pend_lane1;
    exp_swap = pend_swap;
    idle_inputs();
  endtask

  task automatic present(input issue_pkg::instr_t i0, input issue_pkg::instr_t i1);
    dec.instr0 = i0;
    dec.instr1 = i1;
    dec_valid = 1'b1;
  endtask

  task automatic issue_pair(input issue_pkg::instr_t i0, input issue_pkg::instr_t i1);
    present(i0, i1);
    pend_lane0 = expect_lane(i0, 1'b1);
    pend_lane1 = expect_lane(i1, 1'b0);
  endtask

  task automatic expect_bubble();
    exp_stall = 1'b1;
    exp_hold = 1'b1;
  endtask

  task automatic run_tests();
    issue_pkg::instr_t i0;
    issue_pkg::instr_t i1;
    issue_pkg::instr_t ld;
    logic [issue_pkg::reg_addr_w-1:0] w0;
    for (int k = 0; k < reg_writes; k++) begin
      tick();
      wb0 = '{wren: 1'b1, waddr: rand_reg(), wdata: rand_word()};
      wb1 = '{wren: 1'b1, waddr: rand_reg(), wdata: rand_word()};
      // x0 stays zero, wb1 wins a collision.
      if (wb0.waddr != '0) ref_regs[wb0.waddr] = wb0.wdata;
      if (wb1.waddr != '0) ref_regs[wb1.waddr] = wb1.wdata;
    end
    for (int k = 0; k < alu_pairs; k++) begin
      tick();
      i1 = make_instr(issue_pkg::op_alu, 1'b1, rand_reg(), 1'b1, rand_reg(), rand_reg());
      w0 = rand_reg();
      while (w0 == i1.raddr1 || w0 == i1.raddr2) w0 = w0 + 5'd1;
      i0 = make_instr(issue_pkg::op_alu, 1'b1, (k == 0) ? 5'd0 : rand_reg(), 1'b1,
                      rand_reg(), w0);
      issue_pair(i0, i1);
    end
    // alu then load goes out swapped.
    tick();
    i0 = make_instr(issue_pkg::op_alu, 1'b1, 5'd3, 1'b1, 5'd4, 5'd10);
    ld = make_instr(issue_pkg::op_load, 1'b1, 5'd5, 1'b0, 5'd0, 5'd11);
    present(i0, ld);
    pend_lane0 = expect_lane(ld, 1'b1);
    pend_lane1 = expect_lane(i0, 1'b0);
    pend_swap = 1'b1;
    // raw inside the pair splits it.
    tick();
    i1 = make_instr(issue_pkg::op_alu, 1'b1, 5'd10, 1'b1, 5'd6, 5'd12);
    present(i0, i1);
    pend_lane0 = expect_lane(i0, 1'b1);
    exp_hold = 1'b1;
    tick();
    issue_pair(issue_pkg::nop_instr, i1);
    // load and store both want lane 0.
    tick();
    i1 = make_instr(issue_pkg::op_store, 1'b1, 5'd7, 1'b1, 5'd8, 5'd0);
    present(ld, i1);
    pend_lane0 = expect_lane(ld, 1'b1);
    exp_hold = 1'b1;
    tick();
    present(issue_pkg::nop_instr, i1);
    pend_lane0 = expect_lane(i1, 1'b1);
    pend_swap = 1'b1;
    // load-use against both execute slots.
    tick();
    i0 = make_instr(issue_pkg::op_alu, 1'b1, 5'd9, 1'b1, 5'd2, 5'd13);
    i1 = make_instr(issue_pkg::op_alu, 1'b1, 5'd3, 1'b1, 5'd4, 5'd14);
    present(i0, i1);
    ex = '{load0: 1'b1, load1: 1'b0, waddr0: 5'd9, waddr1: 5'd0, cwren: 1'b0, stall: 1'b0};
    expect_bubble();
    tick();
    i0.rden1 = 1'b0;
    issue_pair(i0, i1);
    ex = '{load0: 1'b1, load1: 1'b0, waddr0: 5'd9, waddr1: 5'd0, cwren: 1'b0, stall: 1'b0};
    tick();
    present(i0, i1);
    ex = '{load0: 1'b0, load1: 1'b1, waddr0: 5'd0, waddr1: 5'd4, cwren: 1'b0, stall: 1'b0};
    expect_bubble();
    // csr write then read in lane 0.
    tick();
    csr_wren = 1'b1;
    csr_waddr = issue_pkg::csr_mscratch;
    csr_wdata = rand_word();
    ref_csr[csr_slot(issue_pkg::csr_mscratch)] = csr_wdata;
    tick();
    i0 = make_instr(issue_pkg::op_csrr, 1'b0, 5'd0, 1'b0, 5'd0, 5'd15);
    i0.caddr = issue_pkg::csr_mscratch;
    issue_pair(i0, i1);
    tick();
    present(i0, i1);
    ex.cwren = 1'b1;
    expect_bubble();
    tick();
    present(i0, i1);
    mem.cwren = 1'b1;
    expect_bubble();
    // downstream stall keeps the issue register.
    tick();
    i0 = make_instr(issue_pkg::op_alu, 1'b1, 5'd9, 1'b1, 5'd2, 5'd16);
    issue_pair(i0, i1);
    for (int k = 0; k < 2; k++) begin
      tick();
      present(i1, i0);
      ex.stall = (k == 0);
      mem.stall = (k == 1);
      exp_hold = 1'b1;
      pend_lane0 = exp_lane0;
      pend_lane1 = exp_lane1;
      pend_swap = exp_swap;
    end
    // redirect beats hazard and stall.
    for (int b = 0; b < 3; b++) begin
      tick();
      issue_pair(i1, i0);
      tick();
      present(i0, i1);
      ex = '{load0: 1'b1, load1: 1'b0, waddr0: 5'd9, waddr1: 5'd0, cwren: 1'b1, stall: 1'b1};
      redirect = '{trap: (b == 0), mret: (b == 1), mispredict: (b == 2)};
    end
    tick();
    tick();
  endtask

  initial begin
    seed = 2044;
    reset = 1'b0;
    checking = 1'b0;
    csr_waddr = '0;
    csr_wdata = '0;
    for (int r = 0; r < issue_pkg::reg_count; r++) ref_regs[r] = '0;
    for (int c = 0; c < 4; c++) ref_csr[c] = '0;
    idle_inputs();
    exp_lane0 = bubble();
    exp_lane1 = bubble();
    exp_swap = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b1;
    checking = 1'b1;
    run_tests();
    @(negedge clock);
    #1;
    $display("cycles run: %0d, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
